//--- common/dcache_pkg.sv
/*
 * Data cache shared definitions.
 * Word and line geometry, the CPU and RAM request
 * structs, and the controller state encoding.
 */

package dcache_pkg;

        // ------------------------------
        // Geometry
        // ------------------------------
        localparam int WORD_W     = 32;                  // Data word width.
        localparam int BEN_W      = WORD_W / 8;          // Byte enables per word.
        localparam int LINE_WORDS = 4;                   // Words per line.
        localparam int LINE_W     = WORD_W * LINE_WORDS; // 128-bit line.
        localparam int LINE_BEN_W = BEN_W * LINE_WORDS;  // Byte enables per line.
        localparam int OFFSET_W   = 4;                   // Byte offset bits in a line.

        // ------------------------------
        // Request structs
        // ------------------------------

        // Load/store request from the CPU.
        // Held steady while o_stall is high.
        typedef struct packed {
                logic              rd_en;  // Read request.
                logic              wr_en;  // Write request.
                logic [BEN_W-1:0]  ben;    // Byte enables.
                logic [WORD_W-1:0] addr;   // Byte address.
                logic [WORD_W-1:0] wdata;  // Store data.
        } cpu_req_t;

        // Request to the RAM side, held until i_ram_done.
        typedef struct packed {
                logic              rd_en;  // Word read.
                logic              wr_en;  // Word write.
                logic [BEN_W-1:0]  ben;    // Byte enables.
                logic [WORD_W-1:0] addr;   // Word address.
                logic [WORD_W-1:0] wdata;  // Write data.
        } ram_req_t;

        // ------------------------------
        // Controller states
        // ------------------------------
        typedef enum logic [2:0] {
                IDLE,     // Lookup, hits and writes.
                FILL_0,   // Linefill word 0.
                FILL_1,   // Linefill word 1.
                FILL_2,   // Linefill word 2.
                FILL_3,   // Last word, line and tag written.
                REFRESH   // One cycle before the re-lookup.
        } ctrl_state_e;

endpackage

//--- dcache/tag_store.sv
/*
 * Cache tag RAM.
 * One tag and one valid bit per line, combinational
 * hit compare and a bulk invalidate.
 */

`timescale 1ns/1ps

module tag_store import dcache_pkg::*; #(
        parameter int CACHE_LINES = 16          // Number of lines.
) (
        input  logic              i_clk,
        input  logic              i_reset,  // Clears all valid bits.
        input  logic              i_inv,    // Bulk invalidate strobe.
        input  logic [WORD_W-1:0] i_addr,   // Request address.
        input  logic              i_wen,    // Write tag, set valid.
        output logic              o_hit     // Valid tag match.
);

        localparam int IDX_W = $clog2(CACHE_LINES);
        localparam int TAG_W = WORD_W - IDX_W - OFFSET_W;

        logic [TAG_W-1:0]       tags [CACHE_LINES];  // Tag array.
        logic [CACHE_LINES-1:0] valid;               // Valid bit per line.
        logic [IDX_W-1:0]       idx;
        logic [TAG_W-1:0]       tag;

        // ------------------------------
        // Lookup
        // ------------------------------
        assign idx   = i_addr[OFFSET_W +: IDX_W];
        assign tag   = i_addr[WORD_W-1 -: TAG_W];
        assign o_hit = valid[idx] && (tags[idx] == tag);

        // ------------------------------
        // Update
        // ------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_inv)
                        valid <= '0;          // Everything goes invalid.
                else if (i_wen)
                        valid[idx] <= 1'b1;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_wen)
                        tags[idx] <= tag;     // New line owner.
        end

endmodule

//--- dcache/line_store.sv
/*
 * Cache line RAM.
 * 128-bit lines with a write enable per byte and a
 * combinational read of the indexed line.
 */

`timescale 1ns/1ps

module line_store import dcache_pkg::*; #(
        parameter int CACHE_LINES = 16          // Number of lines.
) (
        input  logic                  i_clk,
        input  logic [WORD_W-1:0]     i_addr,   // Request address.
        input  logic [LINE_BEN_W-1:0] i_ben,    // Byte write enables.
        input  logic [LINE_W-1:0]     i_wdata,  // Line write data.
        output logic [LINE_W-1:0]     o_line    // Indexed line.
);

        localparam int IDX_W  = $clog2(CACHE_LINES);
        localparam int BYTE_W = LINE_W / LINE_BEN_W;

        logic [LINE_W-1:0] mem [CACHE_LINES];  // Line data.
        logic [IDX_W-1:0]  idx;

        assign idx = i_addr[OFFSET_W +: IDX_W];

        // ------------------------------
        // Read
        // ------------------------------
        // Contents only count when the
        // tag store reports a hit.
        assign o_line = mem[idx];

        // ------------------------------
        // Byte-enabled write
        // ------------------------------
        always_ff @(posedge i_clk)
        begin
                for (int b = 0; b < LINE_BEN_W; b++)
                begin
                        if (i_ben[b])
                                mem[idx][b*BYTE_W +: BYTE_W] <= i_wdata[b*BYTE_W +: BYTE_W];
                end
        end

endmodule

//--- dcache/dcache_ctrl.sv
/*
 * Data cache controller.
 * Serves read hits in the request cycle, writes every
 * store through to RAM and runs four-word linefills.
 */

`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
        parameter int CACHE_LINES = 16          // Number of lines.
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  cpu_req_t              i_req,         // Held while stalled.
        input  logic [WORD_W-1:0]     i_ram_rd_data, // RAM read data.
        input  logic                  i_ram_done,    // RAM transfer done.
        input  logic                  i_tag_hit,     // Valid tag match.
        input  logic [LINE_W-1:0]     i_line,        // Indexed line.
        output logic                  o_tag_wen,     // Tag write.
        output logic [LINE_BEN_W-1:0] o_line_ben,    // Line byte enables.
        output logic [LINE_W-1:0]     o_line_wdata,  // Line write data.
        output logic [WORD_W-1:0]     o_rd_data,     // Load data.
        output logic                  o_stall,       // Hold the CPU.
        output ram_req_t              o_ram          // RAM request.
);

        // ------------------------------
        // Address fields
        // ------------------------------
        localparam int IDX_W  = $clog2(CACHE_LINES);
        localparam int TAG_W  = WORD_W - IDX_W - OFFSET_W;
        localparam int WSEL_W = $clog2(LINE_WORDS); // Word in line.
        localparam int BSEL_W = $clog2(BEN_W);      // Byte in word.

        logic [TAG_W-1:0]  req_tag;   // Tag of the request.
        logic [IDX_W-1:0]  req_idx;   // Line index of the request.
        logic [WSEL_W-1:0] word_sel;  // Requested word.
        logic [WSEL_W-1:0] fill_word; // Word being fetched.

        // ------------------------------
        // State and linefill buffer
        // ------------------------------
        ctrl_state_e       state_ff, state_nxt;
        logic [WORD_W-1:0] fill_buf [LINE_WORDS-1]; // Words 0..2 of the line.

        assign req_tag  = i_req.addr[WORD_W-1 -: TAG_W];
        assign req_idx  = i_req.addr[OFFSET_W +: IDX_W];
        assign word_sel = i_req.addr[BSEL_W +: WSEL_W];

        // Load data is always the addressed word of the line.
        assign o_rd_data = i_line[word_sel*WORD_W +: WORD_W];

        always_comb
        begin
                state_nxt    = state_ff;
                o_stall      = 1'b0;
                o_tag_wen    = 1'b0;
                o_line_ben   = '0;
                o_line_wdata = '0;
                o_ram        = '0;
                fill_word    = '0;

                case (state_ff)
                IDLE:
                begin
                        if (i_req.rd_en && !i_tag_hit)
                        begin
                                o_stall   = 1'b1;      // Miss. Start linefill.
                                state_nxt = FILL_0;
                        end
                        else if (i_req.wr_en)
                        begin
                                // Store goes through to RAM.
                                o_ram.wr_en = 1'b1;
                                o_ram.ben   = i_req.ben;
                                o_ram.addr  = i_req.addr;
                                o_ram.wdata = i_req.wdata;
                                o_stall     = !i_ram_done;

                                // Update the line only if present.
                                if (i_ram_done && i_tag_hit)
                                begin
                                        o_line_ben   = LINE_BEN_W'(i_req.ben) << (word_sel * BEN_W);
                                        o_line_wdata = LINE_W'(i_req.wdata) << (word_sel * WORD_W);
                                end
                        end
                end

                FILL_0, FILL_1, FILL_2, FILL_3:
                begin
                        o_stall = 1'b1;

                        case (state_ff)
                        FILL_0:  fill_word = WSEL_W'(0);
                        FILL_1:  fill_word = WSEL_W'(1);
                        FILL_2:  fill_word = WSEL_W'(2);
                        default: fill_word = WSEL_W'(3);
                        endcase

                        // Word read inside the missing line.
                        o_ram.rd_en = 1'b1;
                        o_ram.ben   = '1;
                        o_ram.addr  = {req_tag, req_idx, fill_word, {BSEL_W{1'b0}}};

                        // Full line assembled from the buffer and the last word.
                        o_line_wdata = {i_ram_rd_data, fill_buf[2], fill_buf[1], fill_buf[0]};

                        if (i_ram_done)
                        begin
                                case (state_ff)
                                FILL_0:  state_nxt = FILL_1;
                                FILL_1:  state_nxt = FILL_2;
                                FILL_2:  state_nxt = FILL_3;
                                default:
                                begin
                                        o_line_ben = '1;    // Write whole line.
                                        o_tag_wen  = 1'b1;  // And mark it valid.
                                        state_nxt  = REFRESH;
                                end
                                endcase
                        end
                end

                REFRESH:
                begin
                        o_stall   = 1'b1;  // Line visible next cycle.
                        state_nxt = IDLE;
                end

                default:
                begin
                        state_nxt = IDLE;
                end
                endcase
        end

        // ------------------------------
        // Registers
        // ------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        state_ff <= IDLE;
                else
                        state_ff <= state_nxt;
        end

        // Capture the first three words of the fill.
        always_ff @(posedge i_clk)
        begin
                if (i_ram_done)
                begin
                        case (state_ff)
                        FILL_0:  fill_buf[0] <= i_ram_rd_data;
                        FILL_1:  fill_buf[1] <= i_ram_rd_data;
                        FILL_2:  fill_buf[2] <= i_ram_rd_data;
                        default: ;
                        endcase
                end
        end

endmodule

//--- dcache/dcache_top.sv
/*
 * Data cache top level.
 * Direct-mapped write-through cache between the CPU
 * load/store port and RAM. Connects the controller to
 * the tag store and the line store.
 */

`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
        parameter int CACHE_LINES = 16          // Number of lines, power of two.
) (
        input  logic              i_clk,         // Clock.
        input  logic              i_reset,       // Sync reset, active high.
        input  cpu_req_t          i_req,         // CPU request.
        input  logic              i_cache_inv,   // Invalidate all lines.
        output logic [WORD_W-1:0] o_rd_data,     // Load data.
        output logic              o_stall,       // CPU must hold request.
        output ram_req_t          o_ram,         // RAM request.
        input  logic [WORD_W-1:0] i_ram_rd_data, // RAM read data.
        input  logic              i_ram_done     // RAM transfer done.
);

        // ------------------------------
        // Internal nets
        // ------------------------------
        logic                  tag_hit;    // Valid tag match.
        logic                  tag_wen;    // Tag write strobe.
        logic [LINE_W-1:0]     line;       // Indexed line.
        logic [LINE_BEN_W-1:0] line_ben;   // Line byte enables.
        logic [LINE_W-1:0]     line_wdata; // Line write data.

        // Controller.
        dcache_ctrl #(.CACHE_LINES(CACHE_LINES)) i_dcache_ctrl (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_req         (i_req),
                .i_ram_rd_data (i_ram_rd_data),
                .i_ram_done    (i_ram_done),
                .i_tag_hit     (tag_hit),
                .i_line        (line),
                .o_tag_wen     (tag_wen),
                .o_line_ben    (line_ben),
                .o_line_wdata  (line_wdata),
                .o_rd_data     (o_rd_data),
                .o_stall       (o_stall),
                .o_ram         (o_ram)
        );

        // Tags and valid bits.
        tag_store #(.CACHE_LINES(CACHE_LINES)) i_tag_store (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_inv   (i_cache_inv),
                .i_addr  (i_req.addr),
                .i_wen   (tag_wen),
                .o_hit   (tag_hit)
        );

        // Line data.
        line_store #(.CACHE_LINES(CACHE_LINES)) i_line_store (
                .i_clk   (i_clk),
                .i_addr  (i_req.addr),
                .i_ben   (line_ben),
                .i_wdata (line_wdata),
                .o_line  (line)
        );

endmodule

//--- tb/ram_model.sv
/*
 * Behavioral RAM for the data cache testbench.
 * Word memory that completes each request after a
 * random wait and applies writes under byte enables.
 */

`timescale 1ns/1ps

module ram_model import dcache_pkg::*; #(
        parameter int MEM_WORDS = 1024          // Depth in words.
) (
        input  logic              i_clk,
        input  logic              i_reset,
        input  ram_req_t          i_ram,        // Request from the DUT.
        output logic [WORD_W-1:0] o_rd_data,    // Valid with o_done.
        output logic              o_done,       // Transfer done.
        output int                o_rd_count    // Reads served.
);

        localparam int WIDX_W = $clog2(MEM_WORDS);

        logic [WORD_W-1:0] mem [MEM_WORDS];   // Word storage.
        logic [WIDX_W-1:0] widx;
        logic              busy;              // Request accepted.
        int                wait_cnt;          // Cycles left before done.

        assign widx = i_ram.addr[2 +: WIDX_W];

        // Fill pattern from the whole word address.
        initial
        begin
                for (int i = 0; i < MEM_WORDS; i++)
                        mem[i] = 32'h0f1e_2d3c ^ (32'(i) * 32'h0001_0021);
        end

        always @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_done     <= 1'b0;
                        o_rd_data  <= '0;
                        o_rd_count <= 0;
                        busy       <= 1'b0;
                        wait_cnt   <= 0;
                end
                else
                begin
                        o_done <= 1'b0;
                        if (!busy && !o_done && (i_ram.rd_en || i_ram.wr_en))
                        begin
                                busy     <= 1'b1;
                                wait_cnt <= int'($urandom_range(0, 3));  // Random wait.
                        end
                        else if (busy && wait_cnt > 0)
                                wait_cnt <= wait_cnt - 1;
                        else if (busy)
                        begin
                                busy   <= 1'b0;
                                o_done <= 1'b1;
                                if (i_ram.rd_en)
                                begin
                                        o_rd_data  <= mem[widx];
                                        o_rd_count <= o_rd_count + 1;
                                end
                                // Byte-enabled store.
                                for (int b = 0; b < BEN_W; b++)
                                begin
                                        if (i_ram.wr_en && i_ram.ben[b])
                                                mem[widx][8*b +: 8] <= i_ram.wdata[8*b +: 8];
                                end
                        end
                end
        end

endmodule

//--- tb/tb_dcache.sv
/*
 * Data cache testbench.
 * Directed and random loads and stores checked against a
 * shadow memory, with RAM read traffic monitoring.
 */

`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

        localparam int MEM_WORDS      = 1024;  // RAM model depth.
        localparam int RANDOM_OPS     = 300;
        localparam int ACCESS_TIMEOUT = 200;   // Cycles per CPU access.

        logic              clk;
        logic              reset;
        cpu_req_t          req;
        logic              cache_inv;
        logic [WORD_W-1:0] rd_data;
        logic              stall;
        ram_req_t          ram;
        logic [WORD_W-1:0] ram_rd_data;
        logic              ram_done;
        int                ram_reads;

        logic [WORD_W-1:0] shadow [MEM_WORDS];  // Expected memory image.
        logic [WORD_W-1:0] exp_rd_data;         // Expected load data.
        logic [WORD_W-1:0] rd_addr_q [$];       // RAM read addresses seen.
        int                seen;                // Queue entries already checked.
        int                errors;
        int                checks;

        dcache_top #(.CACHE_LINES(16)) i_dcache_top (
                .i_clk         (clk),
                .i_reset       (reset),
                .i_req         (req),
                .i_cache_inv   (cache_inv),
                .o_rd_data     (rd_data),
                .o_stall       (stall),
                .o_ram         (ram),
                .i_ram_rd_data (ram_rd_data),
                .i_ram_done    (ram_done)
        );

        ram_model #(.MEM_WORDS(MEM_WORDS)) i_ram_model (
                .i_clk      (clk),
                .i_reset    (reset),
                .i_ram      (ram),
                .o_rd_data  (ram_rd_data),
                .o_done     (ram_done),
                .o_rd_count (ram_reads)
        );

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // ------------------------------
        // Reference and checks
        // ------------------------------
        function automatic logic [31:0] init_word(input int i);
                return 32'h0f1e_2d3c ^ (32'(i) * 32'h0001_0021);
        endfunction

        // Word after a store under byte enables.
        function automatic logic [31:0] ref_merge(input logic [31:0] old,
                                                  input logic [31:0] wdata,
                                                  input logic [3:0]  ben);
                logic [31:0] res;
                res = old;
                for (int b = 0; b < 4; b++)
                        if (ben[b])
                                res[8*b +: 8] = wdata[8*b +: 8];
                return res;
        endfunction

        task automatic check_value(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                checks++;
                if (exp !== act)
                begin
                        errors++;
                        $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
                end
        endtask

        task automatic abort_run(input string msg);
                $display("%0t: %s, controller in %s", $time, msg,
                         i_dcache_top.i_dcache_ctrl.state_ff.name());
                $display("Checks: %0d, errors: %0d, RAM reads: %0d", checks, errors, ram_reads);
                $display("Simulation finished: FAIL");
                $finish;
        endtask

        // Checks every completed load.
        initial
        begin
                forever
                begin
                        @(posedge clk);
                        if (!reset && req.rd_en && !stall)
                                check_value("o_rd_data", exp_rd_data, rd_data);
                end
        end

        // RAM read monitor.
        initial
        begin
                forever
                begin
                        @(posedge clk);
                        if (!reset && ram_done && ram.rd_en)
                                rd_addr_q.push_back(ram.addr);
                end
        end

        // ------------------------------
        // CPU side tasks
        // ------------------------------
        task automatic cpu_access(input logic rd, input logic wr, input logic [3:0] ben,
                                  input logic [31:0] addr, input logic [31:0] wdata,
                                  output int cycles);
                bit done;
                done   = 1'b0;
                cycles = 0;
                @(negedge clk);
                req.rd_en = rd;
                req.wr_en = wr;
                req.ben   = ben;
                req.addr  = addr;
                req.wdata = wdata;
                while (!done && cycles < ACCESS_TIMEOUT)
                begin
                        @(posedge clk);
                        cycles++;
                        done = !stall;        // Completes with stall low.
                end
                if (done)
                begin
                        @(negedge clk);
                        req = '0;
                end
                else
                        abort_run("CPU access was not completed before the timeout");
        endtask

        task automatic load(input logic [31:0] addr, output int cycles);
                exp_rd_data = shadow[addr[11:2]];
                cpu_access(1'b1, 1'b0, 4'hf, addr, '0, cycles);
        endtask

        task automatic store(input logic [31:0] addr, input logic [3:0] ben,
                             input logic [31:0] wdata);
                int cycles;
                shadow[addr[11:2]] = ref_merge(shadow[addr[11:2]], wdata, ben);
                cpu_access(1'b0, 1'b1, ben, addr, wdata, cycles);
                check_value("ram_model word", shadow[addr[11:2]], i_ram_model.mem[addr[11:2]]);
        endtask

        // Expects four reads at offsets 0 to 12 of the line.
        task automatic check_linefill(input logic [31:0] addr);
                check_value("o_ram read count", 4, 32'(rd_addr_q.size() - seen));
                for (int j = 0; j < 4 && seen + j < rd_addr_q.size(); j++)
                        check_value("o_ram.addr", {addr[31:4], 4'(j*4)}, rd_addr_q[seen+j]);
                seen = rd_addr_q.size();
        endtask

        task automatic check_no_fill();
                check_value("o_ram read count", 0, 32'(rd_addr_q.size() - seen));
                seen = rd_addr_q.size();
        endtask

        // ------------------------------
        // Stimulus
        // ------------------------------
        initial
        begin
                int          cycles;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] r_addr;
                void'($urandom(1));
                errors    = 0;
                checks    = 0;
                seen      = 0;
                reset     = 1'b1;
                req       = '0;
                cache_inv = 1'b0;
                for (int i = 0; i < MEM_WORDS; i++)
                        shadow[i] = init_word(i);
                repeat (16) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;

                a = 32'h0000_0124;
                b = a + 32'h100;                 // Same index, other tag.

                load(a, cycles);                 // Miss.
                check_linefill(a);
                load(a, cycles);                 // Hit.
                check_no_fill();
                check_value("hit latency", 1, 32'(cycles));

                store(a, 4'hf, 32'hdead_beef);   // Write-through on hit.
                load(a, cycles);
                check_no_fill();

                store(a + 4, 4'b0101, 32'h1122_3344);
                load(a + 4, cycles);
                check_no_fill();
                store(32'h0000_03c8, 4'b1000, 32'haa00_0000);  // Write miss.
                check_no_fill();
                load(32'h0000_03c8, cycles);
                check_linefill(32'h0000_03c8);

                load(b, cycles);                 // Conflicts evict.
                check_linefill(b);
                load(a, cycles);
                check_linefill(a);
                load(b, cycles);
                check_linefill(b);

                @(negedge clk);
                cache_inv = 1'b1;                // Single-cycle strobe.
                @(negedge clk);
                cache_inv = 1'b0;
                load(b, cycles);
                check_linefill(b);

                // Random mix.
                for (int n = 0; n < RANDOM_OPS; n++)
                begin
                        r_addr = {20'b0, 10'($urandom_range(0, MEM_WORDS - 1)), 2'b00};
                        if ($urandom_range(0, 1) == 0)
                                load(r_addr, cycles);
                        else
                                store(r_addr, 4'($urandom_range(1, 15)), $urandom);
                end

                $display("Checks: %0d, errors: %0d, RAM reads: %0d", checks, errors, ram_reads);
                if (errors == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

//--- filelist.f
common/dcache_pkg.sv
dcache/tag_store.sv
dcache/line_store.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
tb/ram_model.sv
tb/tb_dcache.sv

//--- run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_dcache -o tb_dcache
./obj_dir/tb_dcache > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
        echo "Run passed."
        exit 0
else
        echo "Run failed, see sim.log."
        exit 1
fi
